// File: project.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_exec_pkg.sv
src/rv_imm_gen.sv
src/rv_op_decode.sv
src/rv_exec_unit.sv
src/rv_exec_top.sv
bench/tb_exec_top.sv

// File: bench/tb_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module tb_exec_top;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        rd_write;
        logic        taken;
        logic        is_ctrl;                // Target is meaningful
        logic [31:0] target;
        logic        illegal;
        logic [31:0] cycle;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    wire         out_valid;
    wire         rd_write;
    wire         branch_taken;
    wire         illegal;
    wire  [31:0] result;
    wire  [31:0] branch_target;
    wire  [4:0]  rd;

    exp_t        exp_q[$];
    string       name_q[$];
    int          errors = 0;
    int          n_in = 0;
    int          n_out = 0;
    int          cycle = 0;

    logic [31:0] pair_a [4] = '{32'd5, 32'hFFFF_FFF0, 32'd3, 32'd1};
    logic [31:0] pair_b [4] = '{32'd5, 32'd3, 32'hFFFF_FFF0, 32'd2};
    logic [2:0]  br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [6:0]  ill_opc [4] = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111};

    rv_exec_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .out_valid     (out_valid),
        .rd_write      (rd_write),
        .branch_taken  (branch_taken),
        .illegal       (illegal),
        .result        (result),
        .branch_target (branch_target),
        .rd            (rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b, input logic alt);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exp_t ref_exec(input logic [31:0] w, input logic [31:0] pc_in,
                                      input logic [31:0] rs1, input logic [31:0] rs2);
        exp_t        e;
        logic        wr;
        logic        lt_s;
        logic        lt_u;
        logic [31:0] i_imm;
        logic [31:0] b_imm;
        logic [31:0] j_imm;
        i_imm = {{20{w[31]}}, w[31:20]};
        b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        lt_s  = $signed(rs1) < $signed(rs2);
        lt_u  = rs1 < rs2;
        e     = '0;
        e.rd  = w[11:7];
        wr    = 1'b1;
        case (w[6:0])
            `OPC_LUI:   e.result = {w[31:12], 12'b0};
            `OPC_AUIPC: e.result = pc_in + {w[31:12], 12'b0};
            `OPC_JAL, `OPC_JALR: begin
                e.result    = pc_in + 32'd4;   // Link value
                e.taken     = 1'b1;
                e.is_ctrl   = 1'b1;
                e.target    = (w[6:0] == `OPC_JAL) ? pc_in + j_imm : rs1 + i_imm;
                e.target[0] = 1'b0;
            end
            `OPC_BRANCH: begin
                wr          = 1'b0;
                e.is_ctrl   = 1'b1;
                e.target    = pc_in + b_imm;
                e.target[0] = 1'b0;
                case (w[14:12])
                    3'b000:  e.taken = rs1 == rs2;
                    3'b001:  e.taken = rs1 != rs2;
                    3'b100:  e.taken = lt_s;
                    3'b101:  e.taken = !lt_s;
                    3'b110:  e.taken = lt_u;
                    default: e.taken = !lt_u;
                endcase
            end
            `OPC_OP_IMM: e.result = alu_ref(w[14:12], rs1, i_imm, w[14:12] == 3'b101 && w[30]);
            `OPC_OP:     e.result = alu_ref(w[14:12], rs1, rs2, w[30]);
            default: begin
                wr        = 1'b0;
                e.illegal = 1'b1;
            end
        endcase
        e.rd_write = wr && (w[11:7] != 5'd0);
        return e;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] d);
        return {f7, 5'd2, 5'd1, f3, d, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                          input logic [2:0] f3, input logic [4:0] d);
        return {imm, 5'd1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] d);
        return {imm[20], imm[10:1], imm[11], imm[19:12], d, `OPC_JAL};
    endfunction

    task automatic send(input string name, input logic [31:0] w, input logic [31:0] pc_in,
                        input logic [31:0] a, input logic [31:0] b);
        exp_t e;
        @(posedge clk);
        #1;
        in_valid  = 1'b1;
        instr     = w;
        pc        = pc_in;
        rs1_value = a;
        rs2_value = b;
        e         = ref_exec(w, pc_in, a, b);
        e.cycle   = cycle;
        exp_q.push_back(e);
        name_q.push_back(name);
        n_in++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_q.size() != 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for %0d outstanding results", exp_q.size());
            errors++;
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERROR %s %s expected %h actual %h", name, field, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_output(input string name, input exp_t e);
        if (cycle != e.cycle + 1) begin
            $display("%s result came %0d cycles after its input", name, cycle - e.cycle);
            errors++;
        end
        check_value(name, "rd_write", e.rd_write, rd_write);
        check_value(name, "branch_taken", e.taken, branch_taken);
        check_value(name, "illegal", e.illegal, illegal);
        if (e.rd_write) begin
            check_value(name, "result", e.result, result);
            check_value(name, "rd", e.rd, rd);
        end
        if (e.is_ctrl) begin
            check_value(name, "branch_target", e.target, branch_target);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output seen with no instruction outstanding");
                errors++;
            end else begin
                n_out++;
                check_output(name_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    initial begin
        int unsigned seed;
        logic [31:0] w;
        int          kind;
        seed      = 94;
        void'($urandom(seed));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = `NOP_INSTR;
        pc        = '0;
        rs1_value = '0;
        rs2_value = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (10) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || rd_write !== 1'b0 || branch_taken !== 1'b0) begin
                $display("Outputs active after reset with no strobe");
                errors++;
            end
        end

        send("add", enc_r(7'h00, 3'b000, 5'd3), 32'h100, 32'd7, 32'd5);
        send("sub", enc_r(7'h20, 3'b000, 5'd4), 32'h104, 32'd5, 32'd7);
        send("sll", enc_r(7'h00, 3'b001, 5'd5), 32'h108, 32'h1, 32'd33);
        send("slt", enc_r(7'h00, 3'b010, 5'd6), 32'h10C, 32'hFFFF_FFFF, 32'd1);
        send("sltu", enc_r(7'h00, 3'b011, 5'd7), 32'h110, 32'hFFFF_FFFF, 32'd1);
        send("xor", enc_r(7'h00, 3'b100, 5'd8), 32'h114, 32'hA5A5_0F0F, 32'hFFFF_0000);
        send("srl", enc_r(7'h00, 3'b101, 5'd9), 32'h118, 32'h8000_0000, 32'd4);
        send("sra", enc_r(7'h20, 3'b101, 5'd10), 32'h11C, 32'h8000_0000, 32'd4);
        send("or", enc_r(7'h00, 3'b110, 5'd11), 32'h120, 32'h00F0_0F00, 32'h0F00_00F0);
        send("and", enc_r(7'h00, 3'b111, 5'd12), 32'h124, 32'hFF00_FF00, 32'h0FF0_0FF0);
        send("addi", enc_i(`OPC_OP_IMM, 12'hFFF, 3'b000, 5'd13), 32'h128, 32'd10, 32'd0);
        send("slti", enc_i(`OPC_OP_IMM, 12'hFFF, 3'b010, 5'd14), 32'h12C, 32'hFFFF_FFFE, 0);
        send("sltiu", enc_i(`OPC_OP_IMM, 12'hFFF, 3'b011, 5'd15), 32'h130, 32'd5, 32'd0);
        send("srai", enc_i(`OPC_OP_IMM, 12'h403, 3'b101, 5'd16), 32'h134, 32'hF000_0000, 0);
        send("srli", enc_i(`OPC_OP_IMM, 12'h003, 3'b101, 5'd17), 32'h138, 32'hF000_0000, 0);
        send("slli", enc_i(`OPC_OP_IMM, 12'h01F, 3'b001, 5'd18), 32'h13C, 32'd3, 32'd0);
        send("add x0", enc_r(7'h00, 3'b000, 5'd0), 32'h140, 32'd1, 32'd2);
        send("addi x0", enc_i(`OPC_OP_IMM, 12'h001, 3'b000, 5'd0), 32'h144, 32'd1, 32'd0);
        send("lui", {20'hABCDE, 5'd19, `OPC_LUI}, 32'h148, 32'd0, 32'd0);
        send("auipc", {20'h00012, 5'd20, `OPC_AUIPC}, 32'h1000, 32'd0, 32'd0);
        send("jal fwd", enc_j(21'h0_0800, 5'd1), 32'h2000, 32'd0, 32'd0);
        send("jal back", enc_j(21'h1F_FFF0, 5'd1), 32'h2004, 32'd0, 32'd0);
        send("jalr", enc_i(`OPC_JALR, 12'h005, 3'b000, 5'd1), 32'h3000, 32'h4000, 32'd0);

        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 4; p++) begin
                send($sformatf("branch f3=%0d pair %0d", br_f3[f], p),
                     enc_b(p[0] ? 13'h1FF8 : 13'h0040, br_f3[f]), 32'h8000,
                     pair_a[p], pair_b[p]);
            end
        end
        drain();

        for (int k = 0; k < 300; k++) begin
            w    = $urandom;
            kind = $urandom % 8;
            case (kind)
                0: w[6:0] = `OPC_LUI;
                1: w[6:0] = `OPC_AUIPC;
                2: w[6:0] = `OPC_JAL;
                3: begin
                    w[6:0]   = `OPC_JALR;
                    w[14:12] = 3'b000;
                end
                4: begin
                    w[6:0]   = `OPC_BRANCH;
                    w[14:12] = br_f3[$urandom % 6];
                end
                5: begin
                    w[6:0] = `OPC_OP_IMM;
                    if (w[14:12] == 3'b001) w[31:25] = 7'b0;
                    else if (w[14:12] == 3'b101) w[31:25] = {1'b0, w[30], 5'b0};
                end
                6: begin
                    w[6:0] = `OPC_OP;                  // Only sub and sra use funct7
                    if (w[14:12] == 3'b000 || w[14:12] == 3'b101) w[31:25] = {1'b0, w[30], 5'b0};
                    else w[31:25] = 7'b0;
                end
                default: w[6:0] = ill_opc[$urandom % 4];
            endcase
            send("random", w, $urandom & 32'hFFFF_FFFC, $urandom, $urandom);
        end
        drain();

        if (n_out != n_in) begin
            $display("Saw %0d results for %0d instructions", n_out, n_in);
            errors++;
        end
        $display("Checked %0d of %0d results, %0d errors", n_out, n_in, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module rv_exec_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire [`XLEN-1:0]       instr,
    input  wire [`XLEN-1:0]       pc,
    input  wire [`XLEN-1:0]       rs1_value,
    input  wire [`XLEN-1:0]       rs2_value,
    output logic                  out_valid,
    output logic                  rd_write,
    output logic                  branch_taken,
    output logic                  illegal,
    output logic [`XLEN-1:0]      result,
    output logic [`XLEN-1:0]      branch_target,
    output logic [`REG_IDX_W-1:0] rd
);

    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    instr_t           instr_view;
    alu_op_t          alu_op;
    a_sel_t           a_sel;
    b_sel_t           b_sel;
    target_sel_t      target_sel;
    logic             dec_rd_write;
    logic             dec_is_branch;
    logic             dec_illegal;
    logic [`XLEN-1:0] imm;

    assign instr_view = instr;

    rv_op_decode u_decode (
        .instr      (instr_view),
        .alu_op     (alu_op),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .target_sel (target_sel),
        .rd_write   (dec_rd_write),
        .is_branch  (dec_is_branch),
        .illegal    (dec_illegal)
    );

    rv_imm_gen u_imm_gen (
        .instr (instr_view),
        .imm   (imm)
    );

    rv_exec_unit u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .pc            (pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .imm           (imm),
        .rd            (instr_view.r.rd),
        .alu_op        (alu_op),
        .a_sel         (a_sel),
        .b_sel         (b_sel),
        .target_sel    (target_sel),
        .rd_write_in   (dec_rd_write),
        .is_branch     (dec_is_branch),
        .illegal_in    (dec_illegal),
        .out_valid     (out_valid),
        .rd_write      (rd_write),
        .branch_taken  (branch_taken),
        .illegal       (illegal),
        .result        (result),
        .branch_target (branch_target),
        .rd_out        (rd)
    );

endmodule

`default_nettype wire

// File: src/rv_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module rv_exec_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire [`XLEN-1:0]              pc,
    input  wire [`XLEN-1:0]              rs1_value,
    input  wire [`XLEN-1:0]              rs2_value,
    input  wire [`XLEN-1:0]              imm,
    input  wire [`REG_IDX_W-1:0]         rd,
    input  wire rv_exec_pkg::alu_op_t     alu_op,
    input  wire rv_exec_pkg::a_sel_t      a_sel,
    input  wire rv_exec_pkg::b_sel_t      b_sel,
    input  wire rv_exec_pkg::target_sel_t target_sel,
    input  wire                          rd_write_in,
    input  wire                          is_branch,
    input  wire                          illegal_in,
    output logic                         out_valid,
    output logic                         rd_write,
    output logic                         branch_taken,
    output logic                         illegal,
    output logic [`XLEN-1:0]             result,
    output logic [`XLEN-1:0]             branch_target,
    output logic [`REG_IDX_W-1:0]        rd_out
);

    import rv_exec_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] target_sum;
    logic             taken;

    always_comb begin
        case (a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = rs1_value;
        endcase

        case (b_sel)
            B_IMM:   op_b = imm;
            B_FOUR:  op_b = `XLEN'(4);
            default: op_b = rs2_value;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = `XLEN'(op_a < op_b);
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_EQ:   alu_res = `XLEN'(op_a == op_b);
            ALU_NE:   alu_res = `XLEN'(op_a != op_b);
            ALU_LT:   alu_res = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_GE:   alu_res = `XLEN'($signed(op_a) >= $signed(op_b));
            ALU_LTU:  alu_res = `XLEN'(op_a < op_b);
            default:  alu_res = `XLEN'(op_a >= op_b);   // GEU
        endcase
    end

    // Jumps decode as add, branches as a compare
    assign taken      = is_branch && ((alu_op == ALU_ADD) || alu_res[0]);
    assign base       = (target_sel == TGT_RS1) ? rs1_value : pc;
    assign target_sum = base + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            rd_write     <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            out_valid    <= in_valid;
            rd_write     <= in_valid && rd_write_in;
            branch_taken <= in_valid && taken;
            illegal      <= in_valid && illegal_in;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result        <= alu_res;
            branch_target <= {target_sum[`XLEN-1:1], 1'b0};
            rd_out        <= rd;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_op_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_op_decode (
    input  wire rv_isa_pkg::instr_t instr,
    output rv_exec_pkg::alu_op_t     alu_op,
    output rv_exec_pkg::a_sel_t      a_sel,
    output rv_exec_pkg::b_sel_t      b_sel,
    output rv_exec_pkg::target_sel_t target_sel,
    output logic                     rd_write,
    output logic                     is_branch,
    output logic                     illegal
);

    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    logic    shift_alt;
    logic    writes;
    alu_op_t arith_op;
    alu_op_t cmp_op;

    // Bit 30 picks SRA over SRL in both formats
    assign shift_alt = instr.i.imm12[10];

    always_comb begin
        case (instr.r.funct3)
            3'b000:  arith_op = (instr.r.opcode == OPCODE_OP && instr.r.funct7[5]) ?
                                ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = shift_alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase

        case (instr.r.funct3)
            3'b001:  cmp_op = ALU_NE;
            3'b100:  cmp_op = ALU_LT;
            3'b101:  cmp_op = ALU_GE;
            3'b110:  cmp_op = ALU_LTU;
            3'b111:  cmp_op = ALU_GEU;
            default: cmp_op = ALU_EQ;      // Also the reserved 010 and 011
        endcase
    end

    always_comb begin
        alu_op     = ALU_ADD;
        a_sel      = A_RS1;
        b_sel      = B_RS2;
        target_sel = TGT_PC;
        writes     = 1'b1;
        is_branch  = 1'b0;
        illegal    = 1'b0;

        case (instr.r.opcode)
            OPCODE_LUI: begin
                a_sel = A_ZERO;
                b_sel = B_IMM;
            end
            OPCODE_AUIPC: begin
                a_sel = A_PC;
                b_sel = B_IMM;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                a_sel      = A_PC;          // Link value pc + 4
                b_sel      = B_FOUR;
                target_sel = (instr.r.opcode == OPCODE_JALR) ? TGT_RS1 : TGT_PC;
                is_branch  = 1'b1;
            end
            OPCODE_BRANCH: begin
                alu_op    = cmp_op;
                writes    = 1'b0;
                is_branch = 1'b1;
            end
            OPCODE_OP_IMM: begin
                alu_op = arith_op;
                b_sel  = B_IMM;
            end
            OPCODE_OP: begin
                alu_op = arith_op;
            end
            default: begin
                writes  = 1'b0;
                illegal = 1'b1;
            end
        endcase

        rd_write = writes && (instr.r.rd != '0);
    end

endmodule

`default_nettype wire

// File: src/rv_imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module rv_imm_gen (
    input  wire rv_isa_pkg::instr_t instr,
    output logic [`XLEN-1:0]        imm
);

    import rv_isa_pkg::*;

    logic [`XLEN-1:0] w;

    assign w = instr;

    always_comb begin
        case (instr.i.opcode)
            OPCODE_OP_IMM, OPCODE_JALR: begin
                imm = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
            end
            OPCODE_BRANCH: begin
                imm = {{(`XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                imm = {w[31:12], 12'b0};
            end
            OPCODE_JAL: begin
                imm = {{(`XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                imm = '0;                   // R-type and unknown opcodes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR,  ALU_AND,
        ALU_EQ,  ALU_NE,            // Branch compares from here on
        ALU_LT,  ALU_GE,
        ALU_LTU, ALU_GEU
    } alu_op_t;

    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } a_sel_t;

    typedef enum logic [1:0] {
        B_RS2,
        B_IMM,
        B_FOUR
    } b_sel_t;

    typedef enum logic {
        TGT_PC,
        TGT_RS1                     // JALR only
    } target_sel_t;

endpackage

`default_nettype wire

// File: src/rv_isa_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPCODE_LUI    = `OPC_LUI,
        OPCODE_AUIPC  = `OPC_AUIPC,
        OPCODE_JAL    = `OPC_JAL,
        OPCODE_JALR   = `OPC_JALR,
        OPCODE_BRANCH = `OPC_BRANCH,
        OPCODE_OP_IMM = `OPC_OP_IMM,
        OPCODE_OP     = `OPC_OP
    } opcode_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        opcode_t               opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]           imm12;  // Also carries shamt and the shift type bit
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        opcode_t               opcode;
    } i_fields_t;

    // One instruction word, seen as R or I format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

`default_nettype wire

// File: src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define REG_IDX_W   5

// Major opcodes of the kept RV32I subset
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

// add x0, x0, x0
`define NOP_INSTR   32'h00000033

`endif
